/* verilog/stream_pkg.sv */
// stream FIFO definitions shared by the queue, the top level and the testbench
`default_nettype none

package stream_pkg;

  // default queue depth, in entries
  localparam int unsigned FIFO_DEPTH = 4;

  // status flags reported by every FIFO and by the decoupling queue
  typedef struct packed {
    logic empty;                             // no entry stored
    logic full;                              // no free slot left
  } stream_flags_t;

endpackage

`default_nettype wire

/* verilog/tcdm_pkg.sv */
// memory-port widths, word types and request/response structs for the core-to-bank path
`default_nettype none

package tcdm_pkg;

  localparam int unsigned ADDR_W     = 8;            // word address
  localparam int unsigned DATA_W     = 32;           // bus word
  localparam int unsigned BE_W       = DATA_W / 8;   // one enable per byte
  localparam int unsigned BANK_WORDS = 64;           // words in the bank
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS); // index bits into the bank

  typedef logic [ADDR_W-1:0]  tcdm_addr_t;
  typedef logic [DATA_W-1:0]  tcdm_data_t;
  typedef logic [BE_W-1:0]    tcdm_be_t;
  typedef logic [BANK_AW-1:0] tcdm_idx_t;            // low address bits that select a word

  // request beat, 45 bits
  typedef struct packed {
    tcdm_addr_t addr;                        // word address
    tcdm_data_t data;                        // write data, ignored on reads
    tcdm_be_t   be;                          // byte enables for writes
    logic       wen;                         // 1 read, 0 write
  } tcdm_req_t;

  // response beat, read data only
  typedef struct packed {
    tcdm_data_t r_data;
  } tcdm_rsp_t;

  // flat widths for the FIFO payloads
  localparam int unsigned REQ_W = $bits(tcdm_req_t);
  localparam int unsigned RSP_W = $bits(tcdm_rsp_t);

endpackage

`default_nettype wire

/* verilog/stream_fifo.sv */
// registered circular-buffer FIFO with valid/ready ports, instantiated for requests and responses
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int unsigned DEPTH = stream_pkg::FIFO_DEPTH,
  parameter int unsigned WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  clear_i,       // drops all entries
  input  wire logic                  push_valid_i,
  input  wire logic [WIDTH-1:0]      push_data_i,
  output logic                       push_ready_o,
  output logic                       pop_valid_o,
  output logic [WIDTH-1:0]           pop_data_o,
  input  wire logic                  pop_ready_i,
  output stream_pkg::stream_flags_t  flags_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  logic [WIDTH-1:0] mem_q [DEPTH];                   // payload storage, no reset
  ptr_t             wr_ptr_q, rd_ptr_q;
  cnt_t             count_q;
  logic             push_ok, pop_ok;

  assign flags_o.empty = (count_q == '0);
  assign flags_o.full  = (count_q == cnt_t'(DEPTH));
  assign push_ready_o  = ~flags_o.full;
  assign pop_valid_o   = ~flags_o.empty;
  assign pop_data_o    = mem_q[rd_ptr_q];            // head entry, registered

  assign push_ok = push_valid_i & push_ready_o;
  assign pop_ok  = pop_valid_o & pop_ready_i;

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;         // idle or push and pop together
      endcase
    end
  end

  // write port, entry shows at the pop side one cycle later
  always_ff @(posedge clk_i) begin
    if (push_ok && !clear_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // occupancy bound
  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_t'(DEPTH)
  ) else $error("stream_fifo occupancy above depth");

  // a stalled head entry may not change or vanish
  a_pop_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pop_valid_o && !pop_ready_i && !clear_i) |=> (pop_valid_o && $stable(pop_data_o))
  ) else $error("stream_fifo pop data changed while stalled");

endmodule

`default_nettype wire

/* verilog/tcdm_fifo.sv */
// decoupling queue between a core memory port and a bank: request FIFO, response FIFO and skid
`timescale 1ns/1ps
`default_nettype none

module tcdm_fifo #(
  parameter int unsigned DEPTH = stream_pkg::FIFO_DEPTH
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  clear_i,       // empties both FIFOs and the skid
  // core side
  input  wire logic                  core_req_i,
  input  wire tcdm_pkg::tcdm_req_t   core_data_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output tcdm_pkg::tcdm_rsp_t        core_rdata_o,
  input  wire logic                  core_lrdy_i,
  // bank side
  output logic                       bank_req_o,
  output tcdm_pkg::tcdm_req_t        bank_data_o,
  input  wire logic                  bank_gnt_i,
  input  wire logic                  bank_rvalid_i,
  input  wire tcdm_pkg::tcdm_rsp_t   bank_rdata_i,
  output stream_pkg::stream_flags_t  flags_o
);

  stream_pkg::stream_flags_t flags_out, flags_in;

  logic [tcdm_pkg::REQ_W-1:0] out_pop_data;          // flat request at the FIFO head
  logic                       out_pop_valid;
  logic [tcdm_pkg::RSP_W-1:0] in_pop_data;           // flat response at the FIFO head
  logic                       in_push_valid;
  logic                       in_push_ready;         // incoming FIFO can take a beat
  tcdm_pkg::tcdm_rsp_t        in_push_data;

  logic                       skid_valid_q;          // a response is parked
  tcdm_pkg::tcdm_rsp_t        skid_data_q;           // last response seen from the bank

  // outgoing stream, core req/gnt map onto push valid/ready
  stream_fifo #(
    .DEPTH ( DEPTH           ),
    .WIDTH ( tcdm_pkg::REQ_W )
  ) u_fifo_outgoing (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( core_req_i    ),
    .push_data_i  ( core_data_i   ),
    .push_ready_o ( core_gnt_o    ),
    .pop_valid_o  ( out_pop_valid ),
    .pop_data_o   ( out_pop_data  ),
    .pop_ready_i  ( bank_gnt_i    ),       // bank only grants what it was offered
    .flags_o      ( flags_out     )
  );

  assign bank_data_o = tcdm_pkg::tcdm_req_t'(out_pop_data);
  // hold requests back while there is no room for the answer
  assign bank_req_o  = out_pop_valid & in_push_ready;

  // incoming stream, fed by the live response or the parked one
  assign in_push_valid = bank_rvalid_i | skid_valid_q;
  assign in_push_data  = skid_valid_q ? skid_data_q : bank_rdata_i; // parked beat is older

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (clear_i) begin
      skid_valid_q <= 1'b0;
    end else if (in_push_ready) begin
      skid_valid_q <= 1'b0;                  // FIFO takes whatever is offered
    end else if (bank_rvalid_i) begin
      skid_valid_q <= 1'b1;                  // response arrived into a full FIFO
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_rvalid_i) begin
      skid_data_q <= bank_rdata_i;           // keep the newest beat until it is taken
    end
  end

  stream_fifo #(
    .DEPTH ( DEPTH           ),
    .WIDTH ( tcdm_pkg::RSP_W )
  ) u_fifo_incoming (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( in_push_valid ),
    .push_data_i  ( in_push_data  ),
    .push_ready_o ( in_push_ready ),
    .pop_valid_o  ( core_rvalid_o ),
    .pop_data_o   ( in_pop_data   ),
    .pop_ready_i  ( core_lrdy_i   ),       // core level-ready is the only back-pressure
    .flags_o      ( flags_in      )
  );

  assign core_rdata_o = tcdm_pkg::tcdm_rsp_t'(in_pop_data);

  assign flags_o.empty = flags_out.empty & flags_in.empty;
  assign flags_o.full  = flags_out.full;   // full seen from the core side

  // the bank answers only what the queue offers, so the room check on req is enough
  a_gnt_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bank_gnt_i |-> bank_req_o
  ) else $error("tcdm_fifo bank grant without request");

endmodule

`default_nettype wire

/* verilog/tcdm_bank.sv */
// single memory bank model with byte-enable writes, one-cycle read data and a stall level
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 stall_i,         // withholds grants while high
  input  wire logic                 req_i,
  input  wire tcdm_pkg::tcdm_req_t  data_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output tcdm_pkg::tcdm_rsp_t       rdata_o
);

  tcdm_pkg::tcdm_data_t mem_q [tcdm_pkg::BANK_WORDS]; // word storage
  tcdm_pkg::tcdm_idx_t  idx;
  tcdm_pkg::tcdm_data_t rdata_q;                     // read word, no reset
  logic                 rvalid_q;
  logic                 rd_go, wr_go;

  assign gnt_o = req_i & ~stall_i;                   // same-cycle grant
  assign idx   = data_i.addr[tcdm_pkg::BANK_AW-1:0]; // upper address bits ignored
  assign rd_go = gnt_o & data_i.wen;
  assign wr_go = gnt_o & ~data_i.wen;

  // byte-wise write under the enables
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (wr_go) begin
      for (int b = 0; b < tcdm_pkg::BE_W; b++) begin
        if (data_i.be[b]) begin
          mem_q[idx][b*8 +: 8] <= data_i.data[b*8 +: 8];
        end
      end
    end
  end

  // read data captured at the grant edge
  always_ff @(posedge clk_i) begin
    if (rd_go) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_go;                     // writes never answer
    end
  end

  assign rvalid_o       = rvalid_q;
  assign rdata_o.r_data = rdata_q;

  // each response pairs with a read granted one cycle earlier
  a_rvalid_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(req_i && !stall_i && data_i.wen)
  ) else $error("tcdm_bank response without granted read");

endmodule

`default_nettype wire

/* verilog/tcdm_subsystem.sv */
// top level joining the decoupling queue to one memory bank, driven by a core-side port
`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  clear_i,
  input  wire logic                  core_req_i,
  input  wire tcdm_pkg::tcdm_req_t   core_data_i,
  output logic                       core_gnt_o,
  output logic                       core_rvalid_o,
  output tcdm_pkg::tcdm_rsp_t        core_rdata_o,
  input  wire logic                  core_lrdy_i,
  input  wire logic                  bank_stall_i,   // back-pressure from outside
  output stream_pkg::stream_flags_t  flags_o
);

  logic                bank_req, bank_gnt, bank_rvalid;
  tcdm_pkg::tcdm_req_t bank_data;
  tcdm_pkg::tcdm_rsp_t bank_rdata;

  tcdm_fifo #(
    .DEPTH ( stream_pkg::FIFO_DEPTH )
  ) u_tcdm_fifo (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .core_req_i    ( core_req_i    ),
    .core_data_i   ( core_data_i   ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_lrdy_i   ( core_lrdy_i   ),
    .bank_req_o    ( bank_req      ),
    .bank_data_o   ( bank_data     ),
    .bank_gnt_i    ( bank_gnt      ),
    .bank_rvalid_i ( bank_rvalid   ),
    .bank_rdata_i  ( bank_rdata    ),
    .flags_o       ( flags_o       )
  );

  tcdm_bank u_tcdm_bank (
    .clk_i    ( clk_i        ),
    .rst_ni   ( rst_ni       ),
    .stall_i  ( bank_stall_i ),
    .req_i    ( bank_req     ),
    .data_i   ( bank_data    ),
    .gnt_o    ( bank_gnt     ),
    .rvalid_o ( bank_rvalid  ),
    .rdata_o  ( bank_rdata   )
  );

endmodule

`default_nettype wire

/* test/tb_tcdm_tasks.svh */
// directed tests and per-cycle driver helpers, included inside the testbench top module
`ifndef TB_TCDM_TASKS_SVH
`define TB_TCDM_TASKS_SVH
`default_nettype none

  // settles this cycle's handshakes, then moves on to the next falling edge
  task automatic step();
    tcdm_pkg::tcdm_data_t exp_word;
    int unsigned          t_issue;
    if (hold_pend) begin                           // refused beat must still be offered
      check_gnt("core_rvalid_o", core_rvalid, 1'b1);
      check_data("core_rdata_o", core_rdata.r_data, hold_data);
    end
    hold_pend = core_rvalid && !core_lrdy && !clear;
    hold_data = core_rdata.r_data;
    if (core_req && core_gnt && !clear) begin      // clear drops a same-cycle push
      n_grants++;
      if (core_data.wen) begin
        exp_q.push_back(ref_mem[core_data.addr % tcdm_pkg::BANK_WORDS]);
        issue_q.push_back(cyc);
      end else begin
        ref_write(core_data);
      end
    end
    if (core_rvalid && core_lrdy && !clear) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("response 0x%08h arrived with no read outstanding at %0t",
                 core_rdata.r_data, $time);
      end else begin
        exp_word = exp_q.pop_front();
        t_issue  = issue_q.pop_front();
        check_data("core_rdata_o", core_rdata.r_data, exp_word);
        if (lat_check && (cyc - t_issue != READ_LAT)) begin
          n_errors++;
          $display("read answered %0d cycles after its grant, expected %0d", cyc - t_issue,
                   READ_LAT);
        end
      end
    end
    @(negedge clk);
    cyc++;
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) step();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) step();              // watchdog catches a lost response
  endtask

  function automatic tcdm_pkg::tcdm_req_t make_req(input logic rd, input tcdm_pkg::tcdm_addr_t a,
                                                   input tcdm_pkg::tcdm_data_t d,
                                                   input tcdm_pkg::tcdm_be_t be);
    tcdm_pkg::tcdm_req_t r;
    r.addr = a;
    r.data = d;
    r.be   = be;
    r.wen  = rd;                                   // 1 read
    return r;
  endfunction

  // holds req until the queue grants it
  task automatic send(input tcdm_pkg::tcdm_req_t r);
    logic granted;
    core_req  = 1'b1;
    core_data = r;
    do begin
      granted = core_gnt;
      step();
    end while (!granted);
    core_req = 1'b0;
  endtask

  task automatic write_read_back();
    tcdm_pkg::tcdm_addr_t addrs [16];
    foreach (addrs[i]) begin
      addrs[i] = tcdm_pkg::tcdm_addr_t'(lcg_next() >> 16);
      send(make_req(1'b0, addrs[i], lcg_next(), '1));
    end
    lat_check = 1'b1;                              // no stall, no back-pressure here
    foreach (addrs[i]) send(make_req(1'b1, addrs[i], '0, '0));
    drain();
    lat_check = 1'b0;
    idle(2);
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
  endtask

  task automatic partial_writes();
    tcdm_pkg::tcdm_addr_t a;
    tcdm_pkg::tcdm_be_t   be;
    for (int i = 0; i < 8; i++) begin
      a  = tcdm_pkg::tcdm_addr_t'(i * 5);
      be = tcdm_pkg::tcdm_be_t'(lcg_next() >> 20);
      if (be == '1) be = 4'b0110;                  // keep it partial
      send(make_req(1'b0, a, lcg_next(), '1));     // known base word
      send(make_req(1'b0, a, lcg_next(), be));
      send(make_req(1'b1, a, '0, '0));
    end
    drain();
    idle(2);
  endtask

  task automatic stall_fill();
    int unsigned start;
    int unsigned n;
    for (int i = 0; i < DEPTH; i++) begin          // distinct words make order visible
      send(make_req(1'b0, tcdm_pkg::tcdm_addr_t'(8'h10 + i * 3), lcg_next(), '1));
    end
    idle(2);
    bank_stall = 1'b1;
    start      = n_grants;
    core_req   = 1'b1;
    for (int i = 0; i < 2 * DEPTH + 2; i++) begin
      n         = n_grants - start;
      core_data = make_req(1'b1, tcdm_pkg::tcdm_addr_t'(8'h10 + n * 3), '0, '0);
      step();
    end
    core_req = 1'b0;
    n_checks++;
    if (n_grants - start != DEPTH) begin
      n_errors++;
      $display("%0d requests granted under stall, expected %0d", n_grants - start, DEPTH);
    end
    check_gnt("core_gnt_o", core_gnt, 1'b0);
    check_flags("flags_o", flags, flags_value(1'b0, 1'b1));
    bank_stall = 1'b0;
    drain();
    idle(2);
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
  endtask

  task automatic hold_responses();
    core_lrdy = 1'b0;                              // rdata must hold while refused
    for (int i = 0; i < 8; i++) begin
      send(make_req(1'b1, tcdm_pkg::tcdm_addr_t'(lcg_next() >> 16), '0, '0));
    end
    idle(4);
    check_gnt("bank_req", u_tcdm_subsystem.bank_req, 1'b0); // no room for another answer
    core_lrdy = 1'b1;
    drain();
    idle(3);                                       // a duplicate would show here
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
  endtask

  task automatic clear_queue();
    bank_stall = 1'b1;
    for (int i = 0; i < 3; i++) begin
      send(make_req(1'b1, tcdm_pkg::tcdm_addr_t'(i), '0, '0)); // reads only, ref untouched
    end
    clear = 1'b1;
    step();
    clear = 1'b0;
    exp_q.delete();                                // cleared reads owe nothing
    issue_q.delete();
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
    bank_stall = 1'b0;
    idle(8);                                       // any late response is flagged in step
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
  endtask

`default_nettype wire
`endif

/* test/tb_tcdm_subsystem.sv */
// testbench top for the core-to-bank queue, holds the reference model and the compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_subsystem;

  localparam int unsigned DEPTH    = stream_pkg::FIFO_DEPTH;
  localparam int unsigned READ_LAT = 3;            // outgoing FIFO, bank register, incoming FIFO
  localparam int unsigned TEST_LEN = 8 + 48 + 40 + 32 + 40 + 24; // reset plus each test, cycles

  logic                      clk, rst_n, clear, core_req, core_gnt;
  logic                      core_rvalid, core_lrdy, bank_stall;
  tcdm_pkg::tcdm_req_t       core_data;
  tcdm_pkg::tcdm_rsp_t       core_rdata;
  stream_pkg::stream_flags_t flags;

  tcdm_pkg::tcdm_data_t ref_mem [tcdm_pkg::BANK_WORDS]; // expected bank contents
  tcdm_pkg::tcdm_data_t exp_q [$];                 // read words still owed, oldest first
  int unsigned          issue_q [$];               // grant cycle of each owed read
  int unsigned          cyc = 0;
  int unsigned          n_checks = 0;
  int unsigned          n_errors = 0;
  int unsigned          n_grants = 0;
  logic [31:0]          lcg_state = 32'd37047;
  logic                 lat_check = 1'b0;          // read latency checked while set
  logic                 hold_pend = 1'b0;          // response refused in the last cycle
  tcdm_pkg::tcdm_data_t hold_data;

  tcdm_subsystem u_tcdm_subsystem (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .clear_i       ( clear       ),
    .core_req_i    ( core_req    ),
    .core_data_i   ( core_data   ),
    .core_gnt_o    ( core_gnt    ),
    .core_rvalid_o ( core_rvalid ),
    .core_rdata_o  ( core_rdata  ),
    .core_lrdy_i   ( core_lrdy   ),
    .bank_stall_i  ( bank_stall  ),
    .flags_o       ( flags       )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                        // 20 ns period
  end

  // ends a run that stops making progress
  initial begin
    repeat (4 * TEST_LEN) @(posedge clk);
    $display("timeout, the test sequence did not finish within %0d cycles", 4 * TEST_LEN);
    $display("checks %0d, errors %0d", n_checks, n_errors + 1);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic stream_pkg::stream_flags_t flags_value(input logic empty, input logic full);
    stream_pkg::stream_flags_t f;
    f.empty = empty;
    f.full  = full;
    return f;
  endfunction

  // byte-wise update of the expected word
  task automatic ref_write(input tcdm_pkg::tcdm_req_t r);
    int unsigned w;
    w = r.addr % tcdm_pkg::BANK_WORDS;             // upper address bits alias
    for (int b = 0; b < tcdm_pkg::BE_W; b++) begin
      if (r.be[b]) begin
        ref_mem[w][b*8 +: 8] = r.data[b*8 +: 8];
      end
    end
  endtask

  task automatic check_data(input string name, input tcdm_pkg::tcdm_data_t got,
                            input tcdm_pkg::tcdm_data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flags(input string name, input stream_pkg::stream_flags_t got,
                             input stream_pkg::stream_flags_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_gnt(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    clear      = 1'b0;
    core_req   = 1'b0;
    core_data  = '0;
    core_lrdy  = 1'b1;
    bank_stall = 1'b0;
    foreach (ref_mem[w]) ref_mem[w] = '0;          // bank comes out of reset zeroed
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_flags("flags_o", flags, flags_value(1'b1, 1'b0));
    check_gnt("core_gnt_o", core_gnt, 1'b1);
    check_gnt("core_rvalid_o", core_rvalid, 1'b0);
    check_gnt("bank_req", u_tcdm_subsystem.bank_req, 1'b0);
    write_read_back();
    partial_writes();
    stall_fill();
    hold_responses();
    clear_queue();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  `include "tb_tcdm_tasks.svh"

endmodule

`default_nettype wire

/* project.f */
+incdir+test
verilog/stream_pkg.sv
verilog/tcdm_pkg.sv
verilog/stream_fifo.sv
verilog/tcdm_fifo.sv
verilog/tcdm_bank.sv
verilog/tcdm_subsystem.sv
test/tb_tcdm_subsystem.sv
